//--- rtl/gfx_cpu_pkg.sv
package gfx_cpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths

    typedef logic [14:0] cpu_addr_t;    // cpu word address
    typedef logic [15:0] cpu_data_t;
    typedef logic [31:0] axi_cmd_t;     // region one-hot on top, wr/rd at bit 1/0
    typedef logic [5:0]  cs_vec_t;      // active low selects
    typedef logic [10:0] pal_addr_t;
    typedef logic [14:0] rgb_t;         // {b, g, r}

    //////////////////////////////////////////////////////////////////////
    // bus constants

    localparam cpu_data_t BUS_IDLE_DATA = 16'hFFFF;
    localparam cs_vec_t   CS_NONE       = 6'h3F;

    localparam int CMD_REGION_MSB = 31;
    localparam int CMD_REGION_LSB = 26;

    // select bit per region
    localparam int REG_SCROLL = 5;
    localparam int REG_TILE1  = 4;
    localparam int REG_TILE2  = 3;
    localparam int REG_CHAR   = 2;
    localparam int REG_OBJ    = 1;
    localparam int REG_PAL    = 0;

    //////////////////////////////////////////////////////////////////////
    // decoded op and bridge states

    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } bus_op_t;

    typedef enum logic [4:0] {
        ST_STANDBY, ST_OPSTART, ST_BRANCH,
        ST_RD_S0, ST_RD_S1, ST_RD_S2, ST_RD_S3, ST_RD_S4, ST_RD_S5, ST_RD_S6,
        ST_RD_W0, ST_RD_W1,
        ST_WR_S0, ST_WR_S1, ST_WR_S2, ST_WR_S3, ST_WR_S4, ST_WR_S5, ST_WR_S6,
        ST_WR_W0, ST_WR_W1,
        ST_DONE
    } bridge_state_t;

    // select pattern with only one region active
    function automatic cs_vec_t lone_cs(input int idx);
        return ~(cs_vec_t'(1) << idx);
    endfunction

endpackage

//--- rtl/cmd_regs.sv
`timescale 1ns/10ps

module cmd_regs (
    input  logic                    i_EMU_MCLK,
    input  logic                    dtack_set_n,
    input  logic                    i_load,

    input  gfx_cpu_pkg::cpu_addr_t  i_AXI_CPU_ADDR,
    input  gfx_cpu_pkg::cpu_data_t  i_AXI_CPU_DOUT,
    input  gfx_cpu_pkg::axi_cmd_t   i_AXI_CPU_COMMAND,

    output logic                    o_cmd_pending,
    output gfx_cpu_pkg::bus_op_t    o_op,
    output gfx_cpu_pkg::cs_vec_t    o_cs_sel,
    output gfx_cpu_pkg::cpu_addr_t  o_addr,
    output gfx_cpu_pkg::cpu_data_t  o_wdata
);

    import gfx_cpu_pkg::*;

    axi_cmd_t cmd_q;

    // live command, not the latched one
    assign o_cmd_pending = (i_AXI_CPU_COMMAND != '0);

    always_ff @(posedge i_EMU_MCLK or negedge dtack_set_n) begin
        if (!dtack_set_n) begin
            cmd_q <= '0;
        end else if (i_load) begin
            cmd_q <= i_AXI_CPU_COMMAND;
        end
    end

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_load) begin
            o_addr  <= i_AXI_CPU_ADDR;
            o_wdata <= i_AXI_CPU_DOUT;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode

    always_comb begin
        case (cmd_q[1:0])
            2'b01:   o_op = OP_READ;
            2'b10:   o_op = OP_WRITE;
            default: o_op = OP_NONE;    // nop or both bits set
        endcase
    end

    assign o_cs_sel = ~cmd_q[CMD_REGION_MSB:CMD_REGION_LSB];   // one-hot to active low

endmodule

//--- rtl/bus_bridge.sv
`timescale 1ns/10ps

module bus_bridge (
    input  logic                    i_EMU_MCLK,
    input  logic                    dtack_set_n,
    input  logic                    i_EMU_CLK9MPCEN_n,
    input  logic                    i_EMU_CLK9MNCEN_n,

    input  logic                    i_cmd_pending,
    input  gfx_cpu_pkg::bus_op_t    i_op,
    input  gfx_cpu_pkg::cs_vec_t    i_cs_sel,
    input  gfx_cpu_pkg::cpu_addr_t  i_addr,
    input  gfx_cpu_pkg::cpu_data_t  i_wdata,
    input  logic                    i_dtack_n,
    input  gfx_cpu_pkg::cpu_data_t  i_CPU_DIN,
    input  gfx_cpu_pkg::cpu_data_t  i_pal_rdata,

    output logic                    o_load,
    output gfx_cpu_pkg::cpu_addr_t  o_CPU_ADDR,
    output gfx_cpu_pkg::cpu_data_t  o_CPU_DOUT,
    output logic                    o_CPU_RW,
    output logic                    o_CPU_UDS_n,
    output logic                    o_CPU_LDS_n,
    output gfx_cpu_pkg::cs_vec_t    o_cs_n,
    output gfx_cpu_pkg::cpu_data_t  o_AXI_CPU_DIN,
    output logic                    o_AXI_CPU_BUSY
);

    import gfx_cpu_pkg::*;

    bridge_state_t state;
    logic          step_en;
    cpu_data_t     rd_sample;
    logic          ext_one;

    assign o_load = (state == ST_OPSTART);     // host regs captured here

    //////////////////////////////////////////////////////////////////////
    // which 9M phase moves each step

    always_comb begin
        case (state)
            ST_STANDBY, ST_OPSTART, ST_DONE:
                step_en = 1'b1;
            ST_BRANCH, ST_RD_S1, ST_RD_S3, ST_RD_S5, ST_RD_W0,
            ST_WR_S1, ST_WR_S3, ST_WR_S5, ST_WR_W0:
                step_en = ~i_EMU_CLK9MPCEN_n;
            default:
                step_en = ~i_EMU_CLK9MNCEN_n;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // read data source

    assign ext_one = o_cs_n[REG_PAL] && ($countones(~o_cs_n) == 1);

    always_comb begin
        if (o_cs_n == lone_cs(REG_PAL)) begin
            rd_sample = i_pal_rdata;
        end else if (ext_one) begin
            rd_sample = i_CPU_DIN;
        end else begin
            rd_sample = BUS_IDLE_DATA;     // no select or several
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus cycle FSM

    always_ff @(posedge i_EMU_MCLK or negedge dtack_set_n) begin
        if (!dtack_set_n) begin
            state          <= ST_STANDBY;
            o_CPU_ADDR     <= '0;
            o_CPU_DOUT     <= BUS_IDLE_DATA;
            o_AXI_CPU_DIN  <= BUS_IDLE_DATA;
            o_CPU_RW       <= 1'b1;
            o_CPU_UDS_n    <= 1'b1;
            o_CPU_LDS_n    <= 1'b1;
            o_cs_n         <= CS_NONE;
            o_AXI_CPU_BUSY <= 1'b0;
        end else if (step_en) begin
            case (state)
                ST_STANDBY: begin
                    if (i_cmd_pending) state <= ST_OPSTART;
                end
                ST_OPSTART: begin
                    o_AXI_CPU_BUSY <= 1'b1;
                    state          <= ST_BRANCH;
                end
                ST_BRANCH: begin
                    case (i_op)
                        OP_READ:  state <= ST_RD_S0;
                        OP_WRITE: state <= ST_WR_S0;
                        default:  state <= ST_DONE;    // no bus cycle
                    endcase
                end

                // read cycle
                ST_RD_S0: begin
                    o_CPU_ADDR <= i_addr;
                    state      <= ST_RD_S1;
                end
                ST_RD_S1: begin
                    o_cs_n <= i_cs_sel;
                    state  <= ST_RD_S2;
                end
                ST_RD_S2: begin
                    o_CPU_UDS_n <= 1'b0;
                    o_CPU_LDS_n <= 1'b0;
                    state       <= ST_RD_S3;
                end
                ST_RD_S3: state <= ST_RD_S4;
                ST_RD_S4, ST_RD_W1: state <= i_dtack_n ? ST_RD_W0 : ST_RD_S5;
                ST_RD_W0: state <= ST_RD_W1;
                ST_RD_S5: state <= ST_RD_S6;
                ST_RD_S6: begin
                    o_AXI_CPU_DIN <= rd_sample;    // selects still active here
                    o_CPU_UDS_n   <= 1'b1;
                    o_CPU_LDS_n   <= 1'b1;
                    o_cs_n        <= CS_NONE;
                    state         <= ST_DONE;
                end

                // write cycle
                ST_WR_S0: begin
                    o_CPU_ADDR <= i_addr;
                    state      <= ST_WR_S1;
                end
                ST_WR_S1: begin
                    o_cs_n   <= i_cs_sel;
                    o_CPU_RW <= 1'b0;
                    state    <= ST_WR_S2;
                end
                ST_WR_S2: begin
                    o_CPU_DOUT <= i_wdata;
                    state      <= ST_WR_S3;
                end
                ST_WR_S3: begin
                    o_CPU_UDS_n <= 1'b0;
                    o_CPU_LDS_n <= 1'b0;
                    state       <= ST_WR_S4;
                end
                ST_WR_S4, ST_WR_W1: state <= i_dtack_n ? ST_WR_W0 : ST_WR_S5;
                ST_WR_W0: state <= ST_WR_W1;
                ST_WR_S5: state <= ST_WR_S6;
                ST_WR_S6: begin
                    o_CPU_UDS_n <= 1'b1;
                    o_CPU_LDS_n <= 1'b1;
                    o_cs_n      <= CS_NONE;
                    state       <= ST_DONE;
                end

                ST_DONE: begin
                    o_CPU_ADDR     <= '0;
                    o_CPU_DOUT     <= BUS_IDLE_DATA;
                    o_CPU_RW       <= 1'b1;
                    o_AXI_CPU_BUSY <= 1'b0;
                    if (!i_cmd_pending) state <= ST_STANDBY;   // host cleared command
                end
                default: state <= ST_STANDBY;
            endcase
        end
    end

endmodule

//--- rtl/dtack_gen.sv
`timescale 1ns/10ps

module dtack_gen (
    input  logic                    i_EMU_MCLK,
    input  logic                    dtack_set_n,
    input  logic                    i_EMU_CLK6MPCEN_n,
    input  logic                    i_EMU_CLK6MNCEN_n,
    input  logic                    i_ABS_n1H,
    input  logic                    i_ABS_2H,
    input  logic                    i_uds_n,
    input  logic                    i_lds_n,
    input  gfx_cpu_pkg::cs_vec_t    i_cs_n,
    output logic                    o_dtack_n
);

    import gfx_cpu_pkg::*;

    logic       strobe_idle;
    logic       px_04;
    logic [2:0] tmr_en;
    logic [2:0] tmr_n;

    assign strobe_idle = i_uds_n & i_lds_n;
    assign px_04       = ~i_ABS_2H & i_ABS_n1H;    // pixel 0 or 4

    //////////////////////////////////////////////////////////////////////
    // acknowledge timers

    assign tmr_en[0] = ~i_EMU_CLK6MPCEN_n;
    assign tmr_en[1] = ~i_EMU_CLK6MPCEN_n & ~i_ABS_n1H;
    assign tmr_en[2] = ~i_EMU_CLK6MNCEN_n & px_04;     // 6M falling side

    // idle strobes hold all timers at one
    always_ff @(posedge i_EMU_MCLK or negedge dtack_set_n) begin
        if (!dtack_set_n) begin
            tmr_n <= '1;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (strobe_idle || tmr_en[i]) tmr_n[i] <= strobe_idle;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // per-region choice

    always_comb begin
        case (i_cs_n)
            lone_cs(REG_SCROLL),
            lone_cs(REG_OBJ):
                o_dtack_n = tmr_n[1];
            lone_cs(REG_TILE1),
            lone_cs(REG_TILE2),
            lone_cs(REG_CHAR):
                o_dtack_n = tmr_n[2];
            default:
                o_dtack_n = tmr_n[0];   // palette, none, or mixed selects
        endcase
    end

endmodule

//--- rtl/palette_ram.sv
`timescale 1ns/10ps

module palette_ram (
    input  logic                    i_EMU_MCLK,
    input  logic                    i_EMU_CLK6MPCEN_n,
    input  logic                    i_pal_cs_n,
    input  logic                    i_rw,
    input  logic                    i_uds_n,
    input  logic                    i_lds_n,
    input  gfx_cpu_pkg::cpu_addr_t  i_addr,
    input  gfx_cpu_pkg::cpu_data_t  i_wdata,
    input  gfx_cpu_pkg::pal_addr_t  i_CD,
    input  logic                    i_BLK,

    output gfx_cpu_pkg::cpu_data_t  o_pal_rdata,
    output logic [4:0]              o_EMU_VIDEO_R,
    output logic [4:0]              o_EMU_VIDEO_G,
    output logic [4:0]              o_EMU_VIDEO_B
);

    import gfx_cpu_pkg::*;

    logic [7:0] ram_hi [0:2047];
    logic [7:0] ram_lo [0:2047];

    pal_addr_t  ram_addr;
    logic       we_hi;
    logic       we_lo;
    rgb_t       rgb_q;

    // cpu owns the address only while selected
    assign ram_addr = i_pal_cs_n ? i_CD : i_addr[10:0];

    assign we_hi = ~i_pal_cs_n & ~i_rw & ~i_uds_n;
    assign we_lo = ~i_pal_cs_n & ~i_rw & ~i_lds_n;

    //////////////////////////////////////////////////////////////////////
    // byte lanes

    always_ff @(posedge i_EMU_MCLK) begin
        if (we_hi) ram_hi[ram_addr] <= i_wdata[15:8];
        if (we_lo) ram_lo[ram_addr] <= i_wdata[7:0];
        o_pal_rdata <= {ram_hi[ram_addr], ram_lo[ram_addr]};   // one mclk read
    end

    //////////////////////////////////////////////////////////////////////
    // rgb latch and blanking

    always_ff @(posedge i_EMU_MCLK) begin
        if (!i_EMU_CLK6MPCEN_n) begin
            rgb_q <= o_pal_rdata[14:0];    // bit 15 unused
        end
    end

    assign {o_EMU_VIDEO_B, o_EMU_VIDEO_G, o_EMU_VIDEO_R} = rgb_q & {15{i_BLK}};

endmodule

//--- rtl/gfx_cpu.sv
`timescale 1ns/10ps

module gfx_cpu (
    input  logic                    i_EMU_MCLK,
    input  logic                    dtack_set_n,

    input  logic                    i_EMU_CLK9MPCEN_n,
    input  logic                    i_EMU_CLK9MNCEN_n,
    input  logic                    i_EMU_CLK6MPCEN_n,
    input  logic                    i_EMU_CLK6MNCEN_n,

    // external bus
    output gfx_cpu_pkg::cpu_addr_t  o_CPU_ADDR,
    input  gfx_cpu_pkg::cpu_data_t  i_CPU_DIN,
    output gfx_cpu_pkg::cpu_data_t  o_CPU_DOUT,
    output logic                    o_CPU_RW,
    output logic                    o_CPU_UDS_n,
    output logic                    o_CPU_LDS_n,

    output logic                    o_VZCS_n,
    output logic                    o_VCS1_n,
    output logic                    o_VCS2_n,
    output logic                    o_CHACS_n,
    output logic                    o_OBJRAM_n,

    input  logic                    i_BLK,
    input  gfx_cpu_pkg::pal_addr_t  i_CD,
    input  logic                    i_ABS_n1H,
    input  logic                    i_ABS_2H,

    // host side
    input  gfx_cpu_pkg::cpu_addr_t  i_AXI_CPU_ADDR,
    output gfx_cpu_pkg::cpu_data_t  o_AXI_CPU_DIN,
    input  gfx_cpu_pkg::cpu_data_t  i_AXI_CPU_DOUT,
    input  gfx_cpu_pkg::axi_cmd_t   i_AXI_CPU_COMMAND,
    output logic                    o_AXI_CPU_BUSY,

    output logic [4:0]              o_EMU_VIDEO_R,
    output logic [4:0]              o_EMU_VIDEO_G,
    output logic [4:0]              o_EMU_VIDEO_B
);

    import gfx_cpu_pkg::*;

    logic      cmd_pending;
    logic      load;
    logic      dtack_n;
    bus_op_t   op;
    cs_vec_t   cs_sel;
    cs_vec_t   cs_n;
    cpu_addr_t addr;
    cpu_data_t wdata;
    cpu_data_t pal_rdata;

    assign o_VZCS_n   = cs_n[REG_SCROLL];
    assign o_VCS1_n   = cs_n[REG_TILE1];
    assign o_VCS2_n   = cs_n[REG_TILE2];
    assign o_CHACS_n  = cs_n[REG_CHAR];
    assign o_OBJRAM_n = cs_n[REG_OBJ];

    cmd_regs u_cmd_regs (
        .i_EMU_MCLK        (i_EMU_MCLK),
        .dtack_set_n       (dtack_set_n),
        .i_load            (load),
        .i_AXI_CPU_ADDR    (i_AXI_CPU_ADDR),
        .i_AXI_CPU_DOUT    (i_AXI_CPU_DOUT),
        .i_AXI_CPU_COMMAND (i_AXI_CPU_COMMAND),
        .o_cmd_pending     (cmd_pending),
        .o_op              (op),
        .o_cs_sel          (cs_sel),
        .o_addr            (addr),
        .o_wdata           (wdata)
    );

    bus_bridge u_bus_bridge (
        .i_EMU_MCLK        (i_EMU_MCLK),
        .dtack_set_n       (dtack_set_n),
        .i_EMU_CLK9MPCEN_n (i_EMU_CLK9MPCEN_n),
        .i_EMU_CLK9MNCEN_n (i_EMU_CLK9MNCEN_n),
        .i_cmd_pending     (cmd_pending),
        .i_op              (op),
        .i_cs_sel          (cs_sel),
        .i_addr            (addr),
        .i_wdata           (wdata),
        .i_dtack_n         (dtack_n),
        .i_CPU_DIN         (i_CPU_DIN),
        .i_pal_rdata       (pal_rdata),
        .o_load            (load),
        .o_CPU_ADDR        (o_CPU_ADDR),
        .o_CPU_DOUT        (o_CPU_DOUT),
        .o_CPU_RW          (o_CPU_RW),
        .o_CPU_UDS_n       (o_CPU_UDS_n),
        .o_CPU_LDS_n       (o_CPU_LDS_n),
        .o_cs_n            (cs_n),
        .o_AXI_CPU_DIN     (o_AXI_CPU_DIN),
        .o_AXI_CPU_BUSY    (o_AXI_CPU_BUSY)
    );

    dtack_gen u_dtack_gen (
        .i_EMU_MCLK        (i_EMU_MCLK),
        .dtack_set_n       (dtack_set_n),
        .i_EMU_CLK6MPCEN_n (i_EMU_CLK6MPCEN_n),
        .i_EMU_CLK6MNCEN_n (i_EMU_CLK6MNCEN_n),
        .i_ABS_n1H         (i_ABS_n1H),
        .i_ABS_2H          (i_ABS_2H),
        .i_uds_n           (o_CPU_UDS_n),
        .i_lds_n           (o_CPU_LDS_n),
        .i_cs_n            (cs_n),
        .o_dtack_n         (dtack_n)
    );

    palette_ram u_palette_ram (
        .i_EMU_MCLK        (i_EMU_MCLK),
        .i_EMU_CLK6MPCEN_n (i_EMU_CLK6MPCEN_n),
        .i_pal_cs_n        (cs_n[REG_PAL]),
        .i_rw              (o_CPU_RW),
        .i_uds_n           (o_CPU_UDS_n),
        .i_lds_n           (o_CPU_LDS_n),
        .i_addr            (o_CPU_ADDR),
        .i_wdata           (o_CPU_DOUT),
        .i_CD              (i_CD),
        .i_BLK             (i_BLK),
        .o_pal_rdata       (pal_rdata),
        .o_EMU_VIDEO_R     (o_EMU_VIDEO_R),
        .o_EMU_VIDEO_G     (o_EMU_VIDEO_G),
        .o_EMU_VIDEO_B     (o_EMU_VIDEO_B)
    );

endmodule

//--- bench/gfx_cpu_checker.sv
`timescale 1ns/10ps

module gfx_cpu_checker (
    input  logic        i_EMU_MCLK,
    input  logic        i_test_active,
    input  logic        i_test_done,
    input  logic        i_all_done,
    input  logic [3:0]  i_test_op,
    input  logic [3:0]  i_test_region,
    input  logic [15:0] i_test_addr,
    input  logic [15:0] i_test_data,
    input  logic [15:0] i_test_exp,
    input  logic [14:0] i_cpu_addr,
    input  logic        i_cpu_rw,
    input  logic        i_uds_n,
    input  logic        i_lds_n,
    input  logic [15:0] i_cpu_dout,
    input  logic [4:0]  i_ext_cs_n,     // scroll, tile1, tile2, char, sprite
    input  logic [15:0] i_host_din,
    input  logic        i_busy,
    input  logic        i_blk,
    input  logic [14:0] i_rgb,          // {b, g, r}
    output int          o_error_count
);

    int          n_tests;
    int          n_failed;
    int          test_errors;
    logic        strobe_seen;
    logic [4:0]  exp_cs;
    logic [14:0] exp_rgb;

    initial begin
        o_error_count = 0;
        strobe_seen   = 1'b0;
    end

    // pin pattern with only the region's select low, palette has no pin
    function automatic logic [4:0] ext_select(input logic [3:0] region);
        logic [5:0] cs6;
        cs6         = 6'h3F;
        cs6[region] = 1'b0;
        return cs6[5:1];
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] got);
        $display("FAILED %s exp %h got %h", name, exp, got);
        test_errors++;
    endtask

    task automatic report_problem(input string text);
        $display("%s", text);
        test_errors++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // per cycle checks while a row runs

    task automatic watch_cycle();
        exp_cs = ext_select(i_test_region);
        case (i_test_op)
            4'd1, 4'd2: begin
                if (!i_uds_n || !i_lds_n) begin
                    strobe_seen = 1'b1;
                    if ({i_uds_n, i_lds_n} !== 2'b00)
                        report_mismatch("o_CPU_UDS_n/LDS_n", 16'h0, {i_uds_n, i_lds_n});
                    if (i_ext_cs_n !== exp_cs)
                        report_mismatch("o_VZCS_n..o_OBJRAM_n", exp_cs, i_ext_cs_n);
                    if (i_cpu_addr !== i_test_addr[14:0])
                        report_mismatch("o_CPU_ADDR", i_test_addr[14:0], i_cpu_addr);
                    if (i_cpu_rw !== (i_test_op == 4'd1))
                        report_mismatch("o_CPU_RW", (i_test_op == 4'd1), i_cpu_rw);
                    if (i_test_op == 4'd2 && i_cpu_dout !== i_test_data)
                        report_mismatch("o_CPU_DOUT", i_test_data, i_cpu_dout);
                end
            end
            4'd3: begin
                if (!i_uds_n || !i_lds_n) strobe_seen = 1'b1;
                if (i_ext_cs_n !== 5'h1F)
                    report_mismatch("o_VZCS_n..o_OBJRAM_n", 16'h1F, i_ext_cs_n);
            end
            4'd4: begin
                exp_rgb = i_blk ? i_test_exp[14:0] : 15'h0;   // blanked while low
                if (i_rgb !== exp_rgb) report_mismatch("o_EMU_VIDEO_B/G/R", exp_rgb, i_rgb);
            end
            default: ;
        endcase
    endtask

    task automatic close_test();
        case (i_test_op)
            4'd0: begin
                if (i_uds_n !== 1'b1) report_mismatch("o_CPU_UDS_n", 16'h1, i_uds_n);
                if (i_lds_n !== 1'b1) report_mismatch("o_CPU_LDS_n", 16'h1, i_lds_n);
                if (i_cpu_rw !== 1'b1) report_mismatch("o_CPU_RW", 16'h1, i_cpu_rw);
                if (i_ext_cs_n !== 5'h1F)
                    report_mismatch("o_VZCS_n..o_OBJRAM_n", 16'h1F, i_ext_cs_n);
                if (i_busy !== 1'b0) report_mismatch("o_AXI_CPU_BUSY", 16'h0, i_busy);
                if (i_cpu_addr !== 15'h0) report_mismatch("o_CPU_ADDR", 16'h0, i_cpu_addr);
                if (i_cpu_dout !== 16'hFFFF)
                    report_mismatch("o_CPU_DOUT", 16'hFFFF, i_cpu_dout);
            end
            4'd1: begin
                if (!strobe_seen) report_problem("read ran without any data strobe");
                if (i_host_din !== i_test_exp)
                    report_mismatch("o_AXI_CPU_DIN", i_test_exp, i_host_din);
            end
            4'd2: if (!strobe_seen) report_problem("write ran without any data strobe");
            4'd3: begin
                if (strobe_seen) report_problem("strobes seen for a read plus write command");
                if (i_busy !== 1'b0) report_mismatch("o_AXI_CPU_BUSY", 16'h0, i_busy);
            end
            4'd4: ;
            default: report_problem("pattern row has an unknown operation");
        endcase

        n_tests++;
        if (test_errors != 0) n_failed++;
        $display("test %0d op %0d region %0d: %s", n_tests, i_test_op, i_test_region,
                 (test_errors == 0) ? "ok" : "failed");
        o_error_count = o_error_count + test_errors;
        test_errors   = 0;
        strobe_seen   = 1'b0;
    endtask

    always @(posedge i_EMU_MCLK) begin
        if (i_test_done) begin
            close_test();
        end else if (i_test_active) begin
            watch_cycle();
        end
        if (i_all_done) begin
            $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, o_error_count);
        end
    end

endmodule

//--- bench/tb_gfx_cpu.sv
`timescale 1ns/10ps

module tb_gfx_cpu;

    import gfx_cpu_pkg::*;

    localparam int MAX_ROWS   = 32;
    localparam int ROW_CYCLES = 200;

    logic        emu_mclk = 1'b0;
    logic        dtack_set_n;
    logic        cen9p_n;
    logic        cen9n_n;
    logic        cen6p_n;
    logic        cen6n_n;
    logic        abs_n1h;
    logic        abs_2h;
    logic        blk;
    pal_addr_t   cd;
    cpu_data_t   ext_din;
    cpu_addr_t   host_addr;
    cpu_data_t   host_dout;
    axi_cmd_t    host_cmd;

    cpu_addr_t   cpu_addr;
    cpu_data_t   cpu_dout;
    logic        cpu_rw;
    logic        uds_n;
    logic        lds_n;
    logic        vzcs_n;
    logic        vcs1_n;
    logic        vcs2_n;
    logic        chacs_n;
    logic        objram_n;
    cpu_data_t   host_din;
    logic        busy;
    logic [4:0]  vid_r;
    logic [4:0]  vid_g;
    logic [4:0]  vid_b;

    // current row, shared with the checker
    logic [3:0]  t_op;
    logic [3:0]  t_region;
    logic [15:0] t_addr;
    logic [15:0] t_data;
    logic [15:0] t_exp;
    logic        t_active;
    logic        t_done;
    logic        all_done;
    int          error_count;

    logic [15:0] pat_mem [0:5*MAX_ROWS-1];   // five words per row
    int          n_rows;
    int          timeout_cycles;
    int          cycle_cnt;
    int          seed = 63;
    int          div9;
    int          div6;
    logic [1:0]  hcnt = 2'd0;

    gfx_cpu u_dut (
        .i_EMU_MCLK        (emu_mclk),
        .dtack_set_n       (dtack_set_n),
        .i_EMU_CLK9MPCEN_n (cen9p_n),
        .i_EMU_CLK9MNCEN_n (cen9n_n),
        .i_EMU_CLK6MPCEN_n (cen6p_n),
        .i_EMU_CLK6MNCEN_n (cen6n_n),
        .o_CPU_ADDR        (cpu_addr),
        .i_CPU_DIN         (ext_din),
        .o_CPU_DOUT        (cpu_dout),
        .o_CPU_RW          (cpu_rw),
        .o_CPU_UDS_n       (uds_n),
        .o_CPU_LDS_n       (lds_n),
        .o_VZCS_n          (vzcs_n),
        .o_VCS1_n          (vcs1_n),
        .o_VCS2_n          (vcs2_n),
        .o_CHACS_n         (chacs_n),
        .o_OBJRAM_n        (objram_n),
        .i_BLK             (blk),
        .i_CD              (cd),
        .i_ABS_n1H         (abs_n1h),
        .i_ABS_2H          (abs_2h),
        .i_AXI_CPU_ADDR    (host_addr),
        .o_AXI_CPU_DIN     (host_din),
        .i_AXI_CPU_DOUT    (host_dout),
        .i_AXI_CPU_COMMAND (host_cmd),
        .o_AXI_CPU_BUSY    (busy),
        .o_EMU_VIDEO_R     (vid_r),
        .o_EMU_VIDEO_G     (vid_g),
        .o_EMU_VIDEO_B     (vid_b)
    );

    gfx_cpu_checker u_checker (
        .i_EMU_MCLK    (emu_mclk),
        .i_test_active (t_active),
        .i_test_done   (t_done),
        .i_all_done    (all_done),
        .i_test_op     (t_op),
        .i_test_region (t_region),
        .i_test_addr   (t_addr),
        .i_test_data   (t_data),
        .i_test_exp    (t_exp),
        .i_cpu_addr    (cpu_addr),
        .i_cpu_rw      (cpu_rw),
        .i_uds_n       (uds_n),
        .i_lds_n       (lds_n),
        .i_cpu_dout    (cpu_dout),
        .i_ext_cs_n    ({vzcs_n, vcs1_n, vcs2_n, chacs_n, objram_n}),
        .i_host_din    (host_din),
        .i_busy        (busy),
        .i_blk         (blk),
        .i_rgb         ({vid_b, vid_g, vid_r}),
        .o_error_count (error_count)
    );

    initial begin
        forever #2 emu_mclk = ~emu_mclk;
    end

    //////////////////////////////////////////////////////////////////////
    // enables and pixel phase from mclk

    always @(negedge emu_mclk) begin
        div9 = (div9 + 1) % 4;
        div6 = (div6 + 1) % 6;
        if (div6 == 0) hcnt = hcnt + 2'd1;     // steps on 6M rising side
        cen9p_n <= (div9 != 0);
        cen9n_n <= (div9 != 2);
        cen6p_n <= (div6 != 0);
        cen6n_n <= (div6 != 3);
        abs_n1h <= ~hcnt[0];
        abs_2h  <= hcnt[1];
    end

    // external slave answers reads from the address
    always @(negedge emu_mclk) begin
        if (cpu_rw && !(vzcs_n && vcs1_n && vcs2_n && chacs_n && objram_n)) begin
            ext_din <= {1'b0, cpu_addr} ^ 16'h5A5A;
        end else begin
            ext_din <= BUS_IDLE_DATA;
        end
    end

    always @(posedge emu_mclk) begin
        cycle_cnt++;
        if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // row handling

    task automatic load_row(input int row);
        t_op     = pat_mem[5*row][3:0];
        t_region = pat_mem[5*row+1][3:0];
        t_addr   = pat_mem[5*row+2];
        t_data   = pat_mem[5*row+3];
        t_exp    = pat_mem[5*row+4];
    endtask

    task automatic hold_idle();
        t_active = 1'b1;
        repeat (2) @(negedge emu_mclk);
    endtask

    task automatic run_bus_cycle();
        host_addr = t_addr[14:0];
        host_dout = t_data;
        host_cmd  = '0;
        host_cmd[CMD_REGION_LSB + t_region] = 1'b1;
        host_cmd[1:0] = t_op[1:0];             // 1 read, 2 write, 3 both
        t_active  = 1'b1;
        @(negedge emu_mclk);
        while (!busy) @(negedge emu_mclk);
        while (busy) @(negedge emu_mclk);
        host_cmd  = '0;
    endtask

    task automatic check_video();
        logic [31:0] rnd;
        cd = t_addr[10:0];
        repeat (16) @(negedge emu_mclk);       // ram read and a 6M latch
        t_active = 1'b1;
        repeat (16) begin
            rnd = $random(seed);
            blk = rnd[0];
            @(negedge emu_mclk);
        end
        blk = 1'b1;
    endtask

    task automatic end_test();
        t_active = 1'b0;
        t_done   = 1'b1;
        @(negedge emu_mclk);
        t_done   = 1'b0;
    endtask

    task automatic run_rows();
        timeout_cycles = n_rows * ROW_CYCLES;
        repeat (2) @(negedge emu_mclk);
        dtack_set_n = 1'b1;
        for (int row = 0; row < n_rows; row++) begin
            load_row(row);
            case (t_op)
                4'd0:    hold_idle();
                4'd4:    check_video();
                default: run_bus_cycle();
            endcase
            end_test();
        end
        all_done = 1'b1;
        @(negedge emu_mclk);                   // checker prints its counts first
    endtask

    initial begin
        dtack_set_n = 1'b0;
        cen9p_n     = 1'b1;
        cen9n_n     = 1'b1;
        cen6p_n     = 1'b1;
        cen6n_n     = 1'b1;
        abs_n1h     = 1'b1;
        abs_2h      = 1'b0;
        blk         = 1'b1;
        cd          = '0;
        ext_din     = BUS_IDLE_DATA;
        host_addr   = '0;
        host_dout   = '0;
        host_cmd    = '0;
        t_op        = '0;
        t_region    = '0;
        t_addr      = '0;
        t_data      = '0;
        t_exp       = '0;
        t_active    = 1'b0;
        t_done      = 1'b0;
        all_done    = 1'b0;

        $readmemh("bench/gfx_cpu_patterns.txt", pat_mem);
        n_rows = 0;
        while (n_rows < MAX_ROWS && !$isunknown(pat_mem[5*n_rows])) n_rows++;

        if (n_rows == 0) begin
            $display("no rows read from bench/gfx_cpu_patterns.txt");
            $display("Done: errors found");
        end else begin
            run_rows();
            if (error_count == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
        end
        $finish;
    end

endmodule

//--- bench/gfx_cpu_patterns.txt
// columns: op region addr data expected, all hex
// op 0 reset state, 1 read, 2 write, 3 read+write bits, 4 rgb with i_CD = addr
0 0 0000 0000 0000
2 0 0010 1234 1234
1 0 0010 0000 1234
2 0 0123 7c1f 7c1f
1 0 0123 0000 7c1f
2 0 0300 abcd abcd
1 0 0300 0000 abcd
1 5 0100 0000 5b5a
1 4 0222 0000 5878
1 3 1234 0000 486e
1 2 3fff 0000 65a5
1 1 0abc 0000 50e6
2 5 0040 beef beef
2 1 0041 0f0f 0f0f
2 3 0155 a5c3 a5c3
3 4 0200 1111 0000
4 0 0123 0000 7c1f
4 0 0300 0000 2bcd
4 0 0010 0000 1234

//--- vlog.f
rtl/gfx_cpu_pkg.sv
rtl/cmd_regs.sv
rtl/bus_bridge.sv
rtl/dtack_gen.sv
rtl/palette_ram.sv
rtl/gfx_cpu.sv
bench/gfx_cpu_checker.sv
bench/tb_gfx_cpu.sv

//--- Bender.yml
package:
  name: gfx_cpu

sources:
  - files:
      - rtl/gfx_cpu_pkg.sv
      - rtl/cmd_regs.sv
      - rtl/bus_bridge.sv
      - rtl/dtack_gen.sv
      - rtl/palette_ram.sv
      - rtl/gfx_cpu.sv
  - target: test
    files:
      - bench/gfx_cpu_checker.sv
      - bench/tb_gfx_cpu.sv
